//--- cl_code_table.sv
module cl_code_table (
    input  logic                   reset,
    input  logic                   lagger_ram_reset_A,
    input  logic                   table_write,
    input  recode_pkg::cl_symbol_t table_symbol,
    input  recode_pkg::pre_word_t  table_entry,
    input  recode_pkg::cl_symbol_t rd_symbol_a,
    input  recode_pkg::cl_symbol_t rd_symbol_b,
    output logic                   table_ready,
    output recode_pkg::pre_word_t  rd_entry_a,
    output recode_pkg::pre_word_t  rd_entry_b
);

    recode_pkg::pre_word_t mem [recode_pkg::cl_cl_count];

    recode_pkg::cl_index_t sweep_idx;
    logic                  host_write;
    logic                  a_in_range;
    logic                  b_in_range;

    // host writes only land once the sweep is over
    assign host_write = table_ready && table_write &&
                        (table_symbol < recode_pkg::cl_cl_count);

    assign a_in_range = rd_symbol_a < recode_pkg::cl_cl_count;
    assign b_in_range = rd_symbol_b < recode_pkg::cl_cl_count;

    // clearing sweep, one entry per cycle
    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            sweep_idx   <= '0;
            table_ready <= 1'b0;
        end else if (!table_ready) begin
            if (sweep_idx == recode_pkg::cl_last_index) begin
                table_ready <= 1'b1;
            end else begin
                sweep_idx <= sweep_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (!table_ready) begin
            mem[sweep_idx] <= '0;
        end else if (host_write) begin
            mem[table_symbol] <= table_entry;
        end
    end

    // port a serves the recoder
    always_ff @(posedge reset) begin
        if (a_in_range) begin
            rd_entry_a <= mem[rd_symbol_a];
        end else begin
            rd_entry_a <= '0;
        end
    end

    // port b serves the reorder walk
    always_ff @(posedge reset) begin
        if (b_in_range) begin
            rd_entry_b <= mem[rd_symbol_b];
        end else begin
            rd_entry_b <= '0;
        end
    end

endmodule

//--- cl_length_reorder.sv
module cl_length_reorder (
    input  logic                                 reset,
    input  logic                                 lagger_ram_reset_A,
    input  logic                                 block_done,
    output recode_pkg::cl_symbol_t               rd_symbol,
    output logic                                 cl_valid,
    output recode_pkg::pre_word_t                cl_word,
    output logic                                 cl_done,
    output logic [recode_pkg::cl_index_width-1:0] cl_trailing_zeros,
    output logic [recode_pkg::cl_index_width-1:0] cl_length_count,
    input  recode_pkg::pre_word_t                rd_entry
);

    // issue side
    logic                  walking;
    logic                  issue;
    recode_pkg::cl_index_t pos;
    recode_pkg::cl_index_t issue_pos;

    // returned entry side
    logic                  rd_valid;
    logic                  rd_last;
    logic                  cl_last;
    recode_pkg::cl_index_t tail_zeros;
    recode_pkg::pre_count_t entry_length;

    // position 0 goes out in the block_done cycle itself
    assign issue     = block_done || walking;
    assign issue_pos = block_done ? '0 : pos;
    assign rd_symbol = recode_pkg::cl_order(issue_pos);

    assign entry_length = recode_pkg::word_count(rd_entry);

    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            walking <= 1'b0;
            pos     <= '0;
        end else if (block_done) begin
            walking <= 1'b1;
            pos     <= recode_pkg::cl_index_t'(1);
        end else if (walking) begin
            if (pos == recode_pkg::cl_last_index) begin
                walking <= 1'b0;
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            rd_valid          <= 1'b0;
            rd_last           <= 1'b0;
            cl_valid          <= 1'b0;
            cl_last           <= 1'b0;
            cl_done           <= 1'b0;
            tail_zeros        <= '0;
            cl_trailing_zeros <= '0;
            cl_length_count   <= '0;
        end else begin
            rd_valid <= issue;
            rd_last  <= issue && (issue_pos == recode_pkg::cl_last_index);
            cl_valid <= rd_valid;
            cl_last  <= rd_valid && rd_last;
            cl_done  <= cl_last;

            // zero run at the tail, restarted by any nonzero length
            if (block_done) begin
                tail_zeros <= '0;
            end else if (rd_valid) begin
                if (entry_length == '0) begin
                    tail_zeros <= tail_zeros + 1'b1;
                end else begin
                    tail_zeros <= '0;
                end
            end

            if (cl_last) begin
                cl_trailing_zeros <= tail_zeros;
                cl_length_count   <= recode_pkg::cl_index_t'(recode_pkg::cl_cl_count) -
                                     tail_zeros;
            end
        end
    end

    // length word, 3 bits each
    always_ff @(posedge reset) begin
        if (rd_valid) begin
            cl_word <= recode_pkg::make_word(
                recode_pkg::pre_count_t'(recode_pkg::cl_length_field_bits),
                recode_pkg::pre_value_t'(entry_length));
        end
    end

endmodule

//--- cl_symbol_recoder.sv
module cl_symbol_recoder (
    input  logic                                   reset,
    input  logic                                   lagger_ram_reset_A,
    input  logic                                   in_valid,
    input  recode_pkg::pre_word_t                  in_word,
    input  logic                                   in_last,
    output recode_pkg::cl_symbol_t                 rd_symbol,
    output logic                                   out_valid,
    output recode_pkg::pre_word_t                  out_word,
    output logic                                   block_done,
    output logic [recode_pkg::total_bits_width-1:0] total_bits,
    input  recode_pkg::pre_word_t                  rd_entry
);

    // stage one registers
    logic                  s1_valid;
    logic                  s1_extra;
    logic                  s1_last;
    logic                  s1_first;
    recode_pkg::pre_word_t s1_word;

    // input side state
    logic extra_pending;
    logic block_start;
    logic is_repeat;

    // stage two datapath
    recode_pkg::pre_word_t   next_word;
    recode_pkg::total_bits_t base_total;
    recode_pkg::total_bits_t word_bits;

    // table lookup issued straight from the incoming word
    assign rd_symbol = recode_pkg::cl_symbol_t'(recode_pkg::word_value(in_word));

    // 16, 17 and 18 carry an extra-bits word after them
    assign is_repeat = recode_pkg::word_value(in_word) >= recode_pkg::repeat_symbol_min;

    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            extra_pending <= 1'b0;
            block_start   <= 1'b1;
            s1_valid      <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            if (in_valid) begin
                // an extra word never starts another extra word
                extra_pending <= !extra_pending && is_repeat && !in_last;
                block_start   <= in_last;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (in_valid) begin
            s1_word  <= in_word;
            s1_extra <= extra_pending;
            s1_last  <= in_last;
            s1_first <= block_start;
        end
    end

    // code from the table, or the extra word as it came
    assign next_word  = s1_extra ? s1_word : rd_entry;
    assign word_bits  = recode_pkg::total_bits_t'(recode_pkg::word_count(next_word));
    assign base_total = s1_first ? '0 : total_bits;

    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            out_valid  <= 1'b0;
            block_done <= 1'b0;
            total_bits <= '0;
        end else begin
            out_valid  <= s1_valid;
            block_done <= s1_valid && s1_last;
            if (s1_valid) begin
                total_bits <= base_total + word_bits;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (s1_valid) begin
            out_word <= next_word;
        end
    end

endmodule

//--- recode_pkg.sv
package recode_pkg;

    // pre-bitstream word layout, count field above the value field
    localparam int pre_bitstream_width = 21;
    localparam int pre_value_width     = 16;
    localparam int pre_count_width     = 5;
    localparam int pre_count_lsb       = pre_value_width;

    localparam int cl_cl_count          = 19;
    localparam int cl_last_index        = cl_cl_count - 1;
    localparam int cl_symbol_width      = 5;
    localparam int repeat_symbol_min    = 16;
    localparam int cl_length_field_bits = 3;
    localparam int total_bits_width     = 16;
    localparam int cl_index_width       = 5;

    typedef logic [pre_bitstream_width-1:0] pre_word_t;
    typedef logic [pre_value_width-1:0]     pre_value_t;
    typedef logic [pre_count_width-1:0]     pre_count_t;
    typedef logic [cl_symbol_width-1:0]     cl_symbol_t;
    typedef logic [cl_index_width-1:0]      cl_index_t;
    typedef logic [total_bits_width-1:0]    total_bits_t;

    function automatic pre_value_t word_value(input pre_word_t word);
        return word[pre_value_width-1:0];
    endfunction

    function automatic pre_count_t word_count(input pre_word_t word);
        return word[pre_count_lsb +: pre_count_width];
    endfunction

    function automatic pre_word_t make_word(input pre_count_t count, input pre_value_t value);
        return {count, value};
    endfunction

    // deflate transmission order of the code-length code lengths
    function automatic cl_symbol_t cl_order(input cl_index_t pos);
        cl_symbol_t sym;
        case (pos)
            5'd0:    sym = 5'd16;
            5'd1:    sym = 5'd17;
            5'd2:    sym = 5'd18;
            5'd3:    sym = 5'd0;
            5'd4:    sym = 5'd8;
            5'd5:    sym = 5'd7;
            5'd6:    sym = 5'd9;
            5'd7:    sym = 5'd6;
            5'd8:    sym = 5'd10;
            5'd9:    sym = 5'd5;
            5'd10:   sym = 5'd11;
            5'd11:   sym = 5'd4;
            5'd12:   sym = 5'd12;
            5'd13:   sym = 5'd3;
            5'd14:   sym = 5'd13;
            5'd15:   sym = 5'd2;
            5'd16:   sym = 5'd14;
            5'd17:   sym = 5'd1;
            5'd18:   sym = 5'd15;
            default: sym = 5'd0;
        endcase
        return sym;
    endfunction

endpackage

//--- recode_top.f
recode_pkg.sv
cl_code_table.sv
cl_symbol_recoder.sv
cl_length_reorder.sv
recode_top.sv
recode_top_asserts.sv
tb_recode_top.sv

//--- recode_top.sv
module recode_top (
    input  logic                                   reset,
    input  logic                                   lagger_ram_reset_A,
    input  logic                                   table_write,
    input  recode_pkg::cl_symbol_t                 table_symbol,
    input  recode_pkg::pre_word_t                  table_entry,
    input  logic                                   in_valid,
    input  recode_pkg::pre_word_t                  in_word,
    input  logic                                   in_last,
    output logic                                   table_ready,
    output logic                                   out_valid,
    output recode_pkg::pre_word_t                  out_word,
    output logic                                   block_done,
    output logic [recode_pkg::total_bits_width-1:0] total_bits,
    output logic                                   cl_valid,
    output recode_pkg::pre_word_t                  cl_word,
    output logic                                   cl_done,
    output logic [recode_pkg::cl_index_width-1:0]   cl_trailing_zeros,
    output logic [recode_pkg::cl_index_width-1:0]   cl_length_count
);

    // read port a for the recoder, b for the reorder walk
    recode_pkg::cl_symbol_t rd_symbol_a;
    recode_pkg::cl_symbol_t rd_symbol_b;
    recode_pkg::pre_word_t  rd_entry_a;
    recode_pkg::pre_word_t  rd_entry_b;

    cl_code_table u_code_table (
        .reset              (reset),
        .lagger_ram_reset_A (lagger_ram_reset_A),
        .table_write        (table_write),
        .table_symbol       (table_symbol),
        .table_entry        (table_entry),
        .rd_symbol_a        (rd_symbol_a),
        .rd_symbol_b        (rd_symbol_b),
        .table_ready        (table_ready),
        .rd_entry_a         (rd_entry_a),
        .rd_entry_b         (rd_entry_b)
    );

    cl_symbol_recoder u_symbol_recoder (
        .reset              (reset),
        .lagger_ram_reset_A (lagger_ram_reset_A),
        .in_valid           (in_valid),
        .in_word            (in_word),
        .in_last            (in_last),
        .rd_symbol          (rd_symbol_a),
        .out_valid          (out_valid),
        .out_word           (out_word),
        .block_done         (block_done),
        .total_bits         (total_bits),
        .rd_entry           (rd_entry_a)
    );

    // walk starts from the recoder's end of block
    cl_length_reorder u_length_reorder (
        .reset              (reset),
        .lagger_ram_reset_A (lagger_ram_reset_A),
        .block_done         (block_done),
        .rd_symbol          (rd_symbol_b),
        .cl_valid           (cl_valid),
        .cl_word            (cl_word),
        .cl_done            (cl_done),
        .cl_trailing_zeros  (cl_trailing_zeros),
        .cl_length_count    (cl_length_count),
        .rd_entry           (rd_entry_b)
    );

endmodule

//--- recode_top_asserts.sv
module recode_top_checker (
    input logic                                    reset,
    input logic                                    lagger_ram_reset_A,
    input logic                                    table_write,
    input recode_pkg::cl_symbol_t                  table_symbol,
    input recode_pkg::pre_word_t                   table_entry,
    input logic                                    in_valid,
    input recode_pkg::pre_word_t                   in_word,
    input logic                                    in_last,
    input logic                                    table_ready,
    input logic                                    out_valid,
    input recode_pkg::pre_word_t                   out_word,
    input logic                                    block_done,
    input logic [recode_pkg::total_bits_width-1:0] total_bits,
    input logic                                    cl_valid,
    input recode_pkg::pre_word_t                   cl_word,
    input logic                                    cl_done,
    input logic [recode_pkg::cl_index_width-1:0]   cl_trailing_zeros,
    input logic [recode_pkg::cl_index_width-1:0]   cl_length_count
);

    int fail_count = 0;

    recode_pkg::pre_word_t   shadow [19];
    logic [4:0]              order_sym [19];
    logic                    seen_reset;
    logic [4:0]              ready_cycles;
    logic [4:0]              since_done;
    logic [4:0]              walk_pos;
    logic [4:0]              exp_tail;
    logic                    tail_open;
    logic                    extra_next;
    logic                    block_first;
    logic                    s1_valid;
    logic                    s1_last;
    logic                    s1_first;
    logic                    s2_valid;
    logic                    s2_last;
    recode_pkg::pre_word_t   s1_word;
    recode_pkg::pre_word_t   s2_word;
    recode_pkg::pre_word_t   coded_word;
    recode_pkg::pre_word_t   exp_cl_word;
    recode_pkg::pre_value_t  in_value;
    recode_pkg::total_bits_t s2_total;

    initial begin
        order_sym = '{5'd16, 5'd17, 5'd18, 5'd0, 5'd8, 5'd7, 5'd9, 5'd6, 5'd10, 5'd5,
                      5'd11, 5'd4, 5'd12, 5'd3, 5'd13, 5'd2, 5'd14, 5'd1, 5'd15};
    end

    assign in_value    = in_word[recode_pkg::pre_value_width-1:0];
    assign coded_word  = (in_value < 19) ? shadow[in_value[4:0]] : '0;
    assign walk_pos    = since_done - 5'd2;
    assign exp_cl_word = (walk_pos < 19) ?
        {5'd3, 11'd0, shadow[order_sym[walk_pos]][recode_pkg::pre_count_lsb +: 5]} : '0;

    // zero lengths counted back from the end of the order
    always_comb begin
        exp_tail  = '0;
        tail_open = 1'b1;
        for (int p = 18; p >= 0; p--) begin
            if (tail_open && shadow[order_sym[p]][recode_pkg::pre_count_lsb +: 5] == '0) begin
                exp_tail = exp_tail + 1'b1;
            end else begin
                tail_open = 1'b0;
            end
        end
    end

    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            seen_reset   <= 1'b1;
            ready_cycles <= '0;
            since_done   <= 5'd31;
            for (int i = 0; i < 19; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (ready_cycles != 5'd31) begin
                ready_cycles <= ready_cycles + 1'b1;
            end
            if (block_done) begin
                since_done <= 5'd1;
            end else if (since_done != 5'd31) begin
                since_done <= since_done + 1'b1;
            end
            if (table_ready && table_write && table_symbol < 19) begin
                shadow[table_symbol] <= table_entry;
            end
        end
    end

    // two-stage expected output stream
    always_ff @(posedge reset) begin
        if (lagger_ram_reset_A) begin
            extra_next  <= 1'b0;
            block_first <= 1'b1;
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            s2_last     <= 1'b0;
            s2_total    <= '0;
        end else begin
            s1_valid <= in_valid;
            if (in_valid) begin
                extra_next  <= !extra_next && (in_value >= 16) && !in_last;
                block_first <= in_last;
                s1_word     <= extra_next ? in_word : coded_word;
                s1_last     <= in_last;
                s1_first    <= block_first;
            end
            s2_valid <= s1_valid;
            s2_last  <= s1_valid && s1_last;
            if (s1_valid) begin
                s2_word  <= s1_word;
                s2_total <= (s1_first ? 16'd0 : s2_total) +
                            16'(s1_word[recode_pkg::pre_count_lsb +: 5]);
            end
        end
    end

    ready_check: assert property (@(posedge reset)
        seen_reset |-> table_ready == (ready_cycles >= 5'd19))
        else begin
            $error("[FAIL] table_ready got %h expected %h", $sampled(table_ready),
                   $sampled(ready_cycles) >= 5'd19);
            fail_count++;
        end

    out_strobe_check: assert property (@(posedge reset)
        seen_reset |-> (out_valid == s2_valid) && (block_done == s2_last))
        else begin
            $error("out_valid or block_done pulsed in the wrong cycle");
            fail_count++;
        end

    out_word_check: assert property (@(posedge reset) s2_valid |-> out_word == s2_word)
        else begin
            $error("[FAIL] out_word got %h expected %h", $sampled(out_word), $sampled(s2_word));
            fail_count++;
        end

    total_check: assert property (@(posedge reset) block_done |-> total_bits == s2_total)
        else begin
            $error("[FAIL] total_bits got %h expected %h", $sampled(total_bits),
                   $sampled(s2_total));
            fail_count++;
        end

    cl_strobe_check: assert property (@(posedge reset)
        seen_reset |-> (cl_valid == (since_done >= 5'd2 && since_done <= 5'd20)) &&
                       (cl_done == (since_done == 5'd21)))
        else begin
            $error("cl_valid or cl_done pulsed in the wrong cycle");
            fail_count++;
        end

    cl_word_check: assert property (@(posedge reset) cl_valid |-> cl_word == exp_cl_word)
        else begin
            $error("[FAIL] cl_word got %h expected %h", $sampled(cl_word), $sampled(exp_cl_word));
            fail_count++;
        end

    tail_check: assert property (@(posedge reset)
        cl_done |-> (cl_trailing_zeros == exp_tail) && (cl_length_count == 5'd19 - exp_tail))
        else begin
            $error("[FAIL] cl_trailing_zeros/cl_length_count got %h/%h expected %h/%h",
                   $sampled(cl_trailing_zeros), $sampled(cl_length_count),
                   $sampled(exp_tail), 5'd19 - $sampled(exp_tail));
            fail_count++;
        end

endmodule

bind recode_top recode_top_checker u_checker (
    .reset              (reset),
    .lagger_ram_reset_A (lagger_ram_reset_A),
    .table_write        (table_write),
    .table_symbol       (table_symbol),
    .table_entry        (table_entry),
    .in_valid           (in_valid),
    .in_word            (in_word),
    .in_last            (in_last),
    .table_ready        (table_ready),
    .out_valid          (out_valid),
    .out_word           (out_word),
    .block_done         (block_done),
    .total_bits         (total_bits),
    .cl_valid           (cl_valid),
    .cl_word            (cl_word),
    .cl_done            (cl_done),
    .cl_trailing_zeros  (cl_trailing_zeros),
    .cl_length_count    (cl_length_count)
);

//--- tb_recode_top.sv
module tb_recode_top;

    localparam int clk_period      = 10;
    localparam int reset_cycles    = 5;
    localparam int max_block_words = 48;
    localparam int wait_limit      = 64;
    localparam int table_loads     = 9;
    localparam int block_runs      = 10;
    localparam int watchdog_cycles = reset_cycles + wait_limit + table_loads * 21 +
                                     block_runs * (max_block_words + wait_limit + 4) + 200;

    logic                                    reset;
    logic                                    lagger_ram_reset_A;
    logic                                    table_write;
    recode_pkg::cl_symbol_t                  table_symbol;
    recode_pkg::pre_word_t                   table_entry;
    logic                                    in_valid;
    recode_pkg::pre_word_t                   in_word;
    logic                                    in_last;
    logic                                    table_ready;
    logic                                    out_valid;
    recode_pkg::pre_word_t                   out_word;
    logic                                    block_done;
    logic [recode_pkg::total_bits_width-1:0] total_bits;
    logic                                    cl_valid;
    recode_pkg::pre_word_t                   cl_word;
    logic                                    cl_done;
    logic [recode_pkg::cl_index_width-1:0]   cl_trailing_zeros;
    logic [recode_pkg::cl_index_width-1:0]   cl_length_count;

    recode_pkg::pre_word_t block_q [$];
    int tests_run;
    int tests_failed;
    int wait_errors;
    int fails_at_start;

    recode_top u_dut (.*);

    always #(clk_period / 2) reset = ~reset;

    task automatic load_table(input int tail);
        int len;
        recode_pkg::pre_word_t entry;
        for (int p = 0; p < 19; p++) begin
            entry = '0;
            if (p < 19 - tail) begin
                len   = $urandom_range(1, 7);
                entry = {5'(len), 16'($urandom & ((1 << len) - 1))};
            end
            @(posedge reset);
            #1;
            table_write  = 1'b1;
            table_symbol = recode_pkg::cl_order(5'(p));
            table_entry  = entry;
        end
        @(posedge reset);
        #1;
        table_write = 1'b0;
    endtask

    // symbol words carry junk in the count field
    task automatic push_symbol(input int sym);
        block_q.push_back({5'($urandom_range(0, 31)), 16'(sym)});
        if (sym >= 16) begin
            block_q.push_back({5'd7, 16'($urandom & 16'h007f)});
        end
    endtask

    task automatic push_random(input int count, input int top_sym);
        for (int i = 0; i < count; i++) begin
            push_symbol($urandom_range(0, top_sym));
        end
    endtask

    task automatic wait_for_ready();
        int n;
        n = 0;
        while (!table_ready && n < wait_limit) begin
            @(negedge reset);
            n++;
        end
        if (!table_ready) begin
            $display("table_ready did not rise after reset");
            wait_errors++;
        end
    endtask

    task automatic stream_block();
        int n;
        for (int i = 0; i < block_q.size(); i++) begin
            @(posedge reset);
            #1;
            in_valid = 1'b1;
            in_word  = block_q[i];
            in_last  = (i == block_q.size() - 1);
        end
        @(posedge reset);
        #1;
        in_valid = 1'b0;
        in_last  = 1'b0;
        block_q.delete();
        n = 0;
        while (!cl_done && n < wait_limit) begin
            @(negedge reset);
            n++;
        end
        if (!cl_done) begin
            $display("cl_done did not arrive after the block");
            wait_errors++;
        end
        // let the last assertions sample
        repeat (2) @(posedge reset);
    endtask

    task automatic begin_test();
        fails_at_start = u_dut.u_checker.fail_count;
        wait_errors    = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (u_dut.u_checker.fail_count == fails_at_start && wait_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int tail;
        void'($urandom(32'h565b_e413));
        reset              = 1'b0;
        lagger_ram_reset_A = 1'b1;
        table_write        = 1'b0;
        table_symbol       = '0;
        table_entry        = '0;
        in_valid           = 1'b0;
        in_word            = '0;
        in_last            = 1'b0;
        tests_run          = 0;
        tests_failed       = 0;
        repeat (reset_cycles) @(posedge reset);
        #1;
        lagger_ram_reset_A = 1'b0;

        begin_test();
        wait_for_ready();
        push_random(12, 18);
        stream_block();
        end_test("reset_clear");

        begin_test();
        load_table($urandom_range(1, 10));
        push_random(40, 15);
        stream_block();
        end_test("plain_symbols");

        // back-to-back repeats, then a repeat as last-but-one word
        begin_test();
        load_table(0);
        push_symbol(3);
        push_symbol(16);
        push_symbol(17);
        push_symbol(18);
        push_random(10, 18);
        push_symbol(18);
        stream_block();
        push_symbol(17);
        push_random(6, 18);
        stream_block();
        end_test("repeat_symbols");

        begin_test();
        for (int t = 0; t < 6; t++) begin
            if (t == 0) begin
                tail = 19;
            end else if (t == 1) begin
                tail = 0;
            end else begin
                tail = $urandom_range(1, 18);
            end
            load_table(tail);
            push_random(8, 18);
            stream_block();
        end
        end_test("zero_tails");

        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
